// File: mbus_pkg.sv
/*
 * Shared definitions for the wake-up and interrupt path of one bus member
 * layer. Holds the power state encoding, the sleep/isolate drive levels and
 * the register map seen by the layer CPU over APB.
 * Compile this package before every other design file.
 */
`default_nettype none

package mbus_pkg;

   // Power sequencing states, 3 bits wide to leave room for later states
   typedef enum logic [2:0] {
      SLEEP_ALL = 3'd0,
      BC_ON     = 3'd1,
      BC_ACTIVE = 3'd2,
      LC_ACTIVE = 3'd3
   } pwr_state_t;

   // Levels on sleep and isolate controls
   // Hold means asleep or isolated
   localparam logic IO_HOLD    = 1'b1;
   localparam logic IO_RELEASE = 1'b0;

   // Word addresses of the APB register file
   localparam logic [3:0] ADDR_CTRL   = 4'd0;
   localparam logic [3:0] ADDR_TIMER  = 4'd1;
   localparam logic [3:0] ADDR_STATUS = 4'd2;

   // Control register, write-one strobes, read back as zero
   localparam int CTRL_REQ_INT = 0;
   localparam int CTRL_CLR_INT = 1;
   localparam int CTRL_WAKE_LC = 2;
   localparam int CTRL_SLEEP   = 3;

   // Status register fields
   localparam int STAT_STATE_LSB = 0;
   localparam int STAT_STATE_W   = 3;
   localparam int STAT_INT_WIRE  = 4;
   localparam int STAT_INT_BUS   = 5;
   localparam int STAT_BUS_BUSY  = 6;

endpackage

`default_nettype wire

// File: mbus_pwr_if.sv
/*
 * Power control bundle between the power state machine and the blocks that
 * follow its sleep and isolation decisions. The state machine connects to
 * the master modport, everybody else observes through the monitor modport.
 */
`timescale 1ns/1ns
`default_nettype none

interface mbus_pwr_if;
   import mbus_pkg::*;

   // Bus controller and layer controller sleep, bus controller isolation
   logic       mbc_sleep;
   logic       lrc_sleep;
   logic       mbc_isolate;
   // Current power state, for status readback
   pwr_state_t state;

   modport master (
      output mbc_sleep, lrc_sleep, mbc_isolate, state
   );

   modport monitor (
      input mbc_sleep, lrc_sleep, mbc_isolate, state
   );

endinterface

`default_nettype wire

// File: mbus_apb_regs.sv
/*
 * APB slave for the layer CPU. Holds the wake timer period, turns control
 * writes into registered one-cycle command strobes and builds the status
 * word from the live power state and interrupt flags.
 * No wait states: pready is tied high, unmapped addresses flag pslverr.
 */
`timescale 1ns/1ns
`default_nettype none

module mbus_apb_regs #(
   parameter int unsigned TIMER_W = 16
) (
   input  wire                INT_BUSY,
   input  wire                RESETn_local,
   // APB slave
   input  wire                psel,
   input  wire                penable,
   input  wire                pwrite,
   input  wire  [3:0]         paddr,
   input  wire  [31:0]        pwdata,
   output logic [31:0]        prdata,
   output logic               pready,
   output logic               pslverr,
   // Live status sources
   mbus_pwr_if.monitor        pwr,
   input  wire                ext_int_to_wire,
   input  wire                ext_int_to_bus,
   input  wire                bus_busy,
   // Command strobes and timer setting
   output logic               req_int,
   output logic               clr_ext_int,
   output logic               wake_lc,
   output logic               sleep_req,
   output logic [TIMER_W-1:0] timer_period
);
   import mbus_pkg::*;

   logic        access;
   logic        addr_ok;
   logic        ctrl_wr;
   logic [31:0] stat_word;
   logic [31:0] rd_word;

   // Transfer completes in the access phase
   assign access  = psel && penable;
   assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_TIMER) ||
                    (paddr == ADDR_STATUS);
   assign ctrl_wr = access && pwrite && (paddr == ADDR_CTRL);

   assign pready  = 1'b1;
   assign pslverr = access && !addr_ok;

   // Status word from the live state and flags
   always_comb begin
      stat_word = '0;
      stat_word[STAT_STATE_LSB +: STAT_STATE_W] = pwr.state;
      stat_word[STAT_INT_WIRE] = ext_int_to_wire;
      stat_word[STAT_INT_BUS]  = ext_int_to_bus;
      stat_word[STAT_BUS_BUSY] = bus_busy;
   end

   // Read mux, control reads back as zero
   always_comb begin
      case (paddr)
         ADDR_TIMER:  rd_word = 32'(timer_period);
         ADDR_STATUS: rd_word = stat_word;
         default:     rd_word = '0;
      endcase
   end

   // Zero outside a read access
   assign prdata = (access && !pwrite) ? rd_word : '0;

   // Period register and command strobes
   always_ff @(posedge INT_BUSY or negedge RESETn_local) begin
      if (!RESETn_local) begin
         timer_period <= '0;
         req_int      <= 1'b0;
         clr_ext_int  <= 1'b0;
         wake_lc      <= 1'b0;
         sleep_req    <= 1'b0;
      end else begin
         if (access && pwrite && (paddr == ADDR_TIMER))
            timer_period <= TIMER_W'(pwdata);
         // Strobes last one cycle after the access edge
         req_int     <= ctrl_wr && pwdata[CTRL_REQ_INT];
         clr_ext_int <= ctrl_wr && pwdata[CTRL_CLR_INT];
         wake_lc     <= ctrl_wr && pwdata[CTRL_WAKE_LC];
         sleep_req   <= ctrl_wr && pwdata[CTRL_SLEEP];
      end
   end

endmodule

`default_nettype wire

// File: mbus_pwr_fsm.sv
/*
 * Power sequencing for the bus controller and the layer controller.
 * Wakes on a pending bus interrupt or timer expiry, brings the bus
 * controller up one step at a time, and drops everything back to sleep on
 * a sleep command. Restarts the wake timer on each entry into sleep.
 */
`timescale 1ns/1ns
`default_nettype none

module mbus_pwr_fsm (
   input  wire          INT_BUSY,
   input  wire          RESETn_local,
   input  wire          ext_int_to_bus,
   input  wire          timer_expired,
   input  wire          wake_lc,
   input  wire          sleep_req,
   mbus_pwr_if.master   pwr,
   output logic         timer_start
);
   import mbus_pkg::*;

   pwr_state_t state_q;
   pwr_state_t state_d;
   logic       enter_sleep;

   // Next state
   always_comb begin
      state_d = state_q;
      if (sleep_req) begin
         // Sleep wins from every state
         state_d = SLEEP_ALL;
      end else begin
         case (state_q)
            SLEEP_ALL: begin
               // Expiry only counts while asleep
               if (ext_int_to_bus || timer_expired)
                  state_d = BC_ON;
            end
            // Single cycle with power up but still isolated
            BC_ON:     state_d = BC_ACTIVE;
            BC_ACTIVE: begin
               if (wake_lc)
                  state_d = LC_ACTIVE;
            end
            LC_ACTIVE: state_d = LC_ACTIVE;
            default:   state_d = SLEEP_ALL;
         endcase
      end
   end

   // A sleep command while asleep counts as a fresh entry
   assign enter_sleep = (state_d == SLEEP_ALL) &&
                        ((state_q != SLEEP_ALL) || sleep_req);

   always_ff @(posedge INT_BUSY or negedge RESETn_local) begin
      if (!RESETn_local) begin
         state_q     <= SLEEP_ALL;
         // Reset counts as entry into sleep
         timer_start <= 1'b1;
      end else begin
         state_q     <= state_d;
         timer_start <= enter_sleep;
      end
   end

   // Control levels decoded from the state
   always_comb begin
      case (state_q)
         BC_ON: begin
            pwr.mbc_sleep   = IO_RELEASE;
            pwr.mbc_isolate = IO_HOLD;
            pwr.lrc_sleep   = IO_HOLD;
         end
         BC_ACTIVE: begin
            pwr.mbc_sleep   = IO_RELEASE;
            pwr.mbc_isolate = IO_RELEASE;
            pwr.lrc_sleep   = IO_HOLD;
         end
         LC_ACTIVE: begin
            pwr.mbc_sleep   = IO_RELEASE;
            pwr.mbc_isolate = IO_RELEASE;
            pwr.lrc_sleep   = IO_RELEASE;
         end
         default: begin
            // SLEEP_ALL and unused codes hold everything
            pwr.mbc_sleep   = IO_HOLD;
            pwr.mbc_isolate = IO_HOLD;
            pwr.lrc_sleep   = IO_HOLD;
         end
      endcase
   end

   assign pwr.state = state_q;

endmodule

`default_nettype wire

// File: mbus_wake_timer.sv
/*
 * Wake-up down-counter. A start pulse loads the programmed period, the
 * counter then runs once per clock and raises expired for one cycle exactly
 * period cycles after the start pulse. A zero period leaves it idle.
 */
`timescale 1ns/1ns
`default_nettype none

module mbus_wake_timer #(
   parameter int unsigned TIMER_W = 16
) (
   input  wire               INT_BUSY,
   input  wire               RESETn_local,
   input  wire               start,
   input  wire [TIMER_W-1:0] period,
   output logic              expired
);

   logic [TIMER_W-1:0] count;
   logic               active;

   always_ff @(posedge INT_BUSY or negedge RESETn_local) begin
      if (!RESETn_local) begin
         active <= 1'b0;
         count  <= '0;
      end else if (start) begin
         // Restart on every start, even mid count
         active <= (period != '0);
         // Loaded one below so zero lines up with period cycles
         count  <= period - TIMER_W'(1);
      end else if (active) begin
         if (count == '0)
            active <= 1'b0;
         else
            count <= count - TIMER_W'(1);
      end
   end

   // One cycle at zero, then idle
   assign expired = active && (count == '0);

endmodule

`default_nettype wire

// File: mbus_int_ctrl.sv
/*
 * Interrupt qualification for the layer. Tracks whether the bus is busy
 * and decides if a CPU interrupt request may go out, based on the sleep
 * state of both controllers. Drives a one-cycle pulse to the wakeup wire
 * and a held request to the bus, cleared by the CPU.
 */
`timescale 1ns/1ns
`default_nettype none

module mbus_int_ctrl (
   input  wire          INT_BUSY,
   input  wire          RESETn_local,
   mbus_pwr_if.monitor  pwr,
   input  wire          req_int,
   input  wire          clr_ext_int,
   input  wire          bus_active,
   input  wire          mbus_clr_busy,
   input  wire          sc_clr_busy,
   output logic         ext_int_to_wire,
   output logic         ext_int_to_bus,
   output logic         bus_busy
);
   import mbus_pkg::*;

   logic clr_busy;
   logic qualified;

   // Bus side clear is ignored while the bus controller is isolated
   assign clr_busy = sc_clr_busy ||
                     (mbus_clr_busy && (pwr.mbc_isolate == IO_RELEASE));

   // Request qualification on controller sleep levels
   always_comb begin
      qualified = 1'b0;
      case ({pwr.mbc_sleep, pwr.lrc_sleep})
         // Both asleep
         {IO_HOLD, IO_HOLD}:    qualified = req_int;
         // BC up, LC down, only when the bus is idle
         {IO_RELEASE, IO_HOLD}: qualified = req_int && !bus_busy;
         // LC up, or the unreachable BC down / LC up
         default:               qualified = 1'b0;
      endcase
   end

   always_ff @(posedge INT_BUSY or negedge RESETn_local) begin
      if (!RESETn_local) begin
         bus_busy        <= 1'b0;
         ext_int_to_wire <= 1'b0;
         ext_int_to_bus  <= 1'b0;
      end else begin
         // Clear beats set
         if (clr_busy)
            bus_busy <= 1'b0;
         else if (bus_active)
            bus_busy <= 1'b1;
         // Single pulse per request
         ext_int_to_wire <= qualified;
         // Held until the CPU clears it
         if (clr_ext_int)
            ext_int_to_bus <= 1'b0;
         else if (qualified)
            ext_int_to_bus <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: mbus_wakeup_top.sv
/*
 * Top of the layer wake-up and interrupt path. Joins the APB register
 * block, power state machine, wake timer and interrupt controller, and
 * exposes APB and the bus side signals as plain ports.
 */
`timescale 1ns/1ns
`default_nettype none

module mbus_wakeup_top #(
   parameter int unsigned TIMER_W = 16
) (
   input  wire         INT_BUSY,
   input  wire         RESETn_local,
   // APB slave
   input  wire         psel,
   input  wire         penable,
   input  wire         pwrite,
   input  wire  [3:0]  paddr,
   input  wire  [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   // Bus side
   input  wire         bus_active,
   input  wire         mbus_clr_busy,
   input  wire         sc_clr_busy,
   output logic        ext_int_to_wire,
   output logic        ext_int_to_bus,
   output logic        mbc_sleep,
   output logic        lrc_sleep,
   output logic        mbc_isolate
);

   logic               bus_busy;
   logic               req_int;
   logic               clr_ext_int;
   logic               wake_lc;
   logic               sleep_req;
   logic               timer_start;
   logic               timer_expired;
   logic [TIMER_W-1:0] timer_period;

   // Power controls shared by the state machine and its observers
   mbus_pwr_if pwr_bus ();

   mbus_apb_regs #(.TIMER_W(TIMER_W)) u_regs (
      .INT_BUSY, .RESETn_local,
      .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
      .pwr (pwr_bus),
      .ext_int_to_wire, .ext_int_to_bus, .bus_busy,
      .req_int, .clr_ext_int, .wake_lc, .sleep_req, .timer_period
   );

   mbus_pwr_fsm u_fsm (
      .INT_BUSY, .RESETn_local, .ext_int_to_bus, .timer_expired,
      .wake_lc, .sleep_req, .pwr (pwr_bus), .timer_start
   );

   mbus_wake_timer #(.TIMER_W(TIMER_W)) u_timer (
      .INT_BUSY, .RESETn_local, .start (timer_start),
      .period (timer_period), .expired (timer_expired)
   );

   mbus_int_ctrl u_int (
      .INT_BUSY, .RESETn_local, .pwr (pwr_bus),
      .req_int, .clr_ext_int, .bus_active, .mbus_clr_busy, .sc_clr_busy,
      .ext_int_to_wire, .ext_int_to_bus, .bus_busy
   );

   assign mbc_sleep   = pwr_bus.mbc_sleep;
   assign lrc_sleep   = pwr_bus.lrc_sleep;
   assign mbc_isolate = pwr_bus.mbc_isolate;

endmodule

`default_nettype wire

// File: tb_mbus_wakeup.sv
/*
 * Testbench for the layer wake-up and interrupt path. Drives APB and the
 * bus side inputs, runs a cycle model of the power, busy and interrupt
 * rules next to dut0 and compares every output at each falling edge.
 * Six directed tests, one result line each, then a summary.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mbus_wakeup;
   import mbus_pkg::*;

   localparam int TIMER_W = 16;
   // About 300 cycles of tests at the longest timer period, wide margin
   localparam int MAX_CYCLES = 4000;
   localparam int PULSE_ACT  = 0;
   localparam int PULSE_MCLR = 1;
   localparam int PULSE_SCLR = 2;
   localparam logic [31:0] CMD_REQ   = 32'd1 << CTRL_REQ_INT;
   localparam logic [31:0] CMD_CLR   = 32'd1 << CTRL_CLR_INT;
   localparam logic [31:0] CMD_WAKE  = 32'd1 << CTRL_WAKE_LC;
   localparam logic [31:0] CMD_SLEEP = 32'd1 << CTRL_SLEEP;
   // Control levels as {mbc_sleep, lrc_sleep, mbc_isolate}
   localparam logic [2:0] LV_SLEEP     = {IO_HOLD, IO_HOLD, IO_HOLD};
   localparam logic [2:0] LV_BC_ON     = {IO_RELEASE, IO_HOLD, IO_HOLD};
   localparam logic [2:0] LV_BC_ACTIVE = {IO_RELEASE, IO_HOLD, IO_RELEASE};
   localparam logic [2:0] LV_LC_ACTIVE = {IO_RELEASE, IO_RELEASE, IO_RELEASE};

   logic        INT_BUSY;
   logic        RESETn_local;
   logic        psel, penable, pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   wire  [31:0] prdata;
   wire         pready, pslverr;
   logic        bus_active, mbus_clr_busy, sc_clr_busy;
   wire         ext_int_to_wire, ext_int_to_bus;
   wire         mbc_sleep, lrc_sleep, mbc_isolate;

   // Model state
   pwr_state_t  m_state;
   logic        m_busy, m_wire, m_bus;
   logic        m_req, m_clr, m_wake, m_sleep;
   logic [31:0] m_period, m_tper, m_cnt;

   integer      seed;
   int          err_cnt = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          test_err0 = 0;
   int          cycles = 0;

   mbus_wakeup_top #(.TIMER_W(TIMER_W)) dut0 (.*);

   initial INT_BUSY = 1'b0;
   always #5 INT_BUSY = ~INT_BUSY;

   function automatic logic [2:0] levels(input pwr_state_t st);
      case (st)
         BC_ON:     return LV_BC_ON;
         BC_ACTIVE: return LV_BC_ACTIVE;
         LC_ACTIVE: return LV_LC_ACTIVE;
         default:   return LV_SLEEP;
      endcase
   endfunction

   function automatic pwr_state_t next_state(input pwr_state_t st, input logic int_bus,
         input logic expired, input logic wake, input logic sleep);
      // Sleep command wins everywhere
      if (sleep)
         return SLEEP_ALL;
      if (st == SLEEP_ALL && (int_bus || expired))
         return BC_ON;
      if (st == BC_ON)
         return BC_ACTIVE;
      if (st == BC_ACTIVE && wake)
         return LC_ACTIVE;
      return st;
   endfunction

   // Both asleep passes, BC up with LC asleep needs an idle bus
   function automatic logic qualifies(input pwr_state_t st, input logic req,
         input logic busy);
      logic [2:0] lv;
      lv = levels(st);
      if (lv[2] == IO_HOLD && lv[1] == IO_HOLD)
         return req;
      if (lv[1] == IO_HOLD)
         return req && !busy;
      return 1'b0;
   endfunction

   // Bus side clear only counts without isolation
   function automatic logic next_busy(input pwr_state_t st, input logic busy,
         input logic act, input logic mclr, input logic sclr);
      logic [2:0] lv;
      lv = levels(st);
      if (sclr || (mclr && lv[0] == IO_RELEASE))
         return 1'b0;
      return act ? 1'b1 : busy;
   endfunction

   function automatic logic [31:0] status_word(input pwr_state_t st, input logic int_wire,
         input logic int_bus, input logic busy);
      logic [31:0] w;
      w = '0;
      w[STAT_STATE_LSB +: STAT_STATE_W] = st;
      w[STAT_INT_WIRE] = int_wire;
      w[STAT_INT_BUS]  = int_bus;
      w[STAT_BUS_BUSY] = busy;
      return w;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp,
         input logic [31:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // Model advance, inputs are stable at the rising edge
   always @(posedge INT_BUSY or negedge RESETn_local) begin
      logic       expired;
      logic       qual;
      logic       ctrl_wr;
      pwr_state_t st_n;
      if (!RESETn_local) begin
         m_state  = SLEEP_ALL;
         m_busy   = 1'b0;
         m_wire   = 1'b0;
         m_bus    = 1'b0;
         m_req    = 1'b0;
         m_clr    = 1'b0;
         m_wake   = 1'b0;
         m_sleep  = 1'b0;
         m_period = '0;
         m_tper   = '0;
         // Reset counts as entry into sleep
         m_cnt    = '0;
      end else begin
         ctrl_wr = psel && penable && pwrite && (paddr == ADDR_CTRL);
         // Expiry P cycles after the start pulse that follows entry
         expired = (m_state == SLEEP_ALL) && (m_tper != '0) && (m_cnt == m_tper);
         st_n    = next_state(m_state, m_bus, expired, m_wake, m_sleep);
         qual    = qualifies(m_state, m_req, m_busy);
         m_busy  = next_busy(m_state, m_busy, bus_active, mbus_clr_busy, sc_clr_busy);
         m_wire  = qual;
         m_bus   = m_clr ? 1'b0 : (qual ? 1'b1 : m_bus);
         if (st_n == SLEEP_ALL && (m_state != SLEEP_ALL || m_sleep)) begin
            m_cnt = '0;
         end else begin
            // Period taken at the start pulse
            if (m_cnt == '0)
               m_tper = m_period;
            m_cnt = m_cnt + 32'd1;
         end
         m_state = st_n;
         if (psel && penable && pwrite && paddr == ADDR_TIMER)
            m_period = 32'(pwdata[TIMER_W-1:0]);
         m_req   = ctrl_wr && pwdata[CTRL_REQ_INT];
         m_clr   = ctrl_wr && pwdata[CTRL_CLR_INT];
         m_wake  = ctrl_wr && pwdata[CTRL_WAKE_LC];
         m_sleep = ctrl_wr && pwdata[CTRL_SLEEP];
      end
   end

   // Compare at the falling edge
   always @(negedge INT_BUSY) begin
      logic [2:0]  lv;
      logic [31:0] rd;
      if (RESETn_local) begin
         lv = levels(m_state);
         rd = '0;
         if (psel && penable && !pwrite && paddr == ADDR_TIMER)
            rd = m_period;
         if (psel && penable && !pwrite && paddr == ADDR_STATUS)
            rd = status_word(m_state, m_wire, m_bus, m_busy);
         check_val("mbc_sleep", 32'(lv[2]), 32'(mbc_sleep));
         check_val("lrc_sleep", 32'(lv[1]), 32'(lrc_sleep));
         check_val("mbc_isolate", 32'(lv[0]), 32'(mbc_isolate));
         check_val("ext_int_to_wire", 32'(m_wire), 32'(ext_int_to_wire));
         check_val("ext_int_to_bus", 32'(m_bus), 32'(ext_int_to_bus));
         check_val("pready", 32'd1, 32'(pready));
         check_val("pslverr", 32'(psel && penable && paddr > ADDR_STATUS), 32'(pslverr));
         check_val("prdata", rd, prdata);
      end
   end

   always @(posedge INT_BUSY) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $finish;
      end
   end

   // Setup, access, idle; returns 1 ns after the access edge
   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
         output logic [31:0] rdata, output logic err);
      @(posedge INT_BUSY);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(posedge INT_BUSY);
      #1;
      penable = 1'b1;
      @(negedge INT_BUSY);
      rdata = prdata;
      err   = pslverr;
      @(posedge INT_BUSY);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, addr, data, rd, err);
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
      logic err;
      apb_access(1'b0, addr, '0, data, err);
   endtask

   task automatic pulse_input(input int which);
      @(posedge INT_BUSY);
      #1;
      bus_active    = (which == PULSE_ACT);
      mbus_clr_busy = (which == PULSE_MCLR);
      sc_clr_busy   = (which == PULSE_SCLR);
      @(posedge INT_BUSY);
      #1;
      bus_active    = 1'b0;
      mbus_clr_busy = 1'b0;
      sc_clr_busy   = 1'b0;
   endtask

   // n more rising edges, then look at the falling edge
   task automatic settle(input int n);
      repeat (n) @(posedge INT_BUSY);
      @(negedge INT_BUSY);
   endtask

   task automatic expect_pins(input logic int_wire, input logic int_bus, input logic [2:0] lv);
      check_val("ext_int_to_wire", 32'(int_wire), 32'(ext_int_to_wire));
      check_val("ext_int_to_bus", 32'(int_bus), 32'(ext_int_to_bus));
      check_val("{mbc_sleep,lrc_sleep,mbc_isolate}", 32'(lv),
                32'({mbc_sleep, lrc_sleep, mbc_isolate}));
   endtask

   task automatic expect_status(input pwr_state_t st, input logic busy, input logic int_bus);
      logic [31:0] rd;
      apb_read(ADDR_STATUS, rd);
      check_val("status", status_word(st, 1'b0, int_bus, busy), rd);
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err0) begin
         pass_cnt++;
         $display("%0t: %s: pass", $time, name);
      end else begin
         fail_cnt++;
         $display("%0t: %s: fail, %0d errors", $time, name, err_cnt - test_err0);
      end
      test_err0 = err_cnt;
   endtask

   initial begin
      logic [31:0] rd;
      logic        err;
      int          per;
      int          n;
      seed          = 32'h0cfaecbe;
      RESETn_local  = 1'b0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      bus_active    = 1'b0;
      mbus_clr_busy = 1'b0;
      sc_clr_busy   = 1'b0;
      repeat (10) @(posedge INT_BUSY);
      #1;
      RESETn_local = 1'b1;

      expect_status(SLEEP_ALL, 1'b0, 1'b0);
      apb_write(ADDR_TIMER, 32'h0000_beef);
      apb_read(ADDR_TIMER, rd);
      check_val("timer readback", 32'h0000_beef, rd);
      apb_write(ADDR_TIMER, 32'h0);
      apb_access(1'b0, 4'd9, 32'h0, rd, err);
      check_val("pslverr on unmapped read", 32'd1, 32'(err));
      end_test("register access");

      // Request with everything asleep, then the wake sequence
      apb_write(ADDR_CTRL, CMD_REQ);
      settle(1);
      expect_pins(1'b1, 1'b1, LV_SLEEP);
      settle(0);
      expect_pins(1'b0, 1'b1, LV_BC_ON);
      settle(0);
      expect_pins(1'b0, 1'b1, LV_BC_ACTIVE);
      apb_write(ADDR_CTRL, CMD_CLR);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_BC_ACTIVE);
      end_test("interrupt while asleep");

      repeat ($unsigned($random(seed)) % 5) @(posedge INT_BUSY);
      pulse_input(PULSE_ACT);
      apb_write(ADDR_CTRL, CMD_REQ);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_BC_ACTIVE);
      expect_status(BC_ACTIVE, 1'b1, 1'b0);
      pulse_input(PULSE_SCLR);
      apb_write(ADDR_CTRL, CMD_REQ);
      settle(1);
      expect_pins(1'b1, 1'b1, LV_BC_ACTIVE);
      apb_write(ADDR_CTRL, CMD_CLR);
      end_test("busy gating with LC asleep");

      apb_write(ADDR_CTRL, CMD_SLEEP);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_SLEEP);
      pulse_input(PULSE_ACT);
      pulse_input(PULSE_MCLR);
      expect_status(SLEEP_ALL, 1'b1, 1'b0);
      pulse_input(PULSE_SCLR);
      expect_status(SLEEP_ALL, 1'b0, 1'b0);
      apb_write(ADDR_CTRL, CMD_REQ);
      settle(4);
      expect_pins(1'b0, 1'b1, LV_BC_ACTIVE);
      apb_write(ADDR_CTRL, CMD_CLR);
      pulse_input(PULSE_ACT);
      pulse_input(PULSE_MCLR);
      expect_status(BC_ACTIVE, 1'b0, 1'b0);
      end_test("busy clear and isolation");

      per = 4 + int'($unsigned($random(seed)) % 37);
      apb_write(ADDR_TIMER, 32'(per));
      apb_write(ADDR_CTRL, CMD_SLEEP);
      // Entry edge into sleep
      settle(1);
      expect_pins(1'b0, 1'b0, LV_SLEEP);
      n = 0;
      while (mbc_sleep == IO_HOLD && n < 100) begin
         settle(1);
         n++;
      end
      assert (mbc_sleep == IO_RELEASE) else begin
         $display("Timer with period %0d never woke the node", per);
         err_cnt++;
      end
      check_val("edges from sleep to wake", 32'(per + 1), 32'(n));
      apb_write(ADDR_TIMER, 32'h0);
      apb_write(ADDR_CTRL, CMD_SLEEP);
      settle(60);
      expect_pins(1'b0, 1'b0, LV_SLEEP);
      end_test("timer wake-up");

      apb_write(ADDR_CTRL, CMD_REQ);
      settle(4);
      apb_write(ADDR_CTRL, CMD_CLR);
      apb_write(ADDR_CTRL, CMD_WAKE);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_LC_ACTIVE);
      // LC awake, requests go nowhere
      apb_write(ADDR_CTRL, CMD_REQ);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_LC_ACTIVE);
      apb_write(ADDR_CTRL, CMD_SLEEP);
      settle(2);
      expect_pins(1'b0, 1'b0, LV_SLEEP);
      end_test("layer controller awake");

      $display("Tests passed: %0d, failed: %0d, check errors: %0d",
               pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
mbus_pkg.sv
mbus_pwr_if.sv
mbus_apb_regs.sv
mbus_pwr_fsm.sv
mbus_wake_timer.sv
mbus_int_ctrl.sv
mbus_wakeup_top.sv
tb_mbus_wakeup.sv

// File: Makefile
# Verilator build and run of the layer wake-up testbench
VERILATOR ?= verilator
TOP       ?= tb_mbus_wakeup
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
